// ==== sublane_pkg.sv ====
package sublane_pkg;

   localparam int VLANE_NUM       = 8;
   localparam int MEM_DEPTH       = 512;    // words per lane slice
   localparam int MAX_VL_PER_LANE = 256;
   localparam int RD_PORTS        = 3;      // vs1, vs2, vs3

   localparam int ADDR_W = $clog2(MEM_DEPTH);
   localparam int VL_W   = $clog2(VLANE_NUM * MAX_VL_PER_LANE) + 1;  // holds full length
   localparam int DLY_W  = $clog2(MAX_VL_PER_LANE);

   typedef enum logic [1:0] {
      SEW_BYTE = 2'b00,
      SEW_HALF = 2'b01,
      SEW_WORD = 2'b10
   } sew_e;

   // 2'b11 carries no instruction
   typedef enum logic [1:0] {
      KIND_NORMAL = 2'b00,
      KIND_STORE  = 2'b01,
      KIND_LOAD   = 2'b10
   } inst_kind_e;

   typedef struct packed {
      inst_kind_e                      kind;
      logic [VL_W-1:0]                 vl;          // elements over all lanes
      sew_e                            rd_sew;
      sew_e                            wr_sew;
      logic [ADDR_W-1:0]               wr_base;
      logic [RD_PORTS-1:0][ADDR_W-1:0] rd_base;
      logic [DLY_W-1:0]                inst_delay;  // first read to first write
   } inst_cfg_t;

   typedef struct packed {
      logic                            en;
      logic [RD_PORTS-1:0][ADDR_W-1:0] addr;
      logic [VLANE_NUM-1:0]            valid;       // one bit per lane
   } vrf_rd_t;

   typedef struct packed {
      logic                            en;
      logic [ADDR_W-1:0]               addr;        // same word in every lane
      logic [VLANE_NUM-1:0][3:0]       bwen;
      logic                            src_load;    // 0 alu result, 1 load data
   } vrf_wr_t;

endpackage

// ==== sublane_ctrl.sv ====
`timescale 1ns/10ps

module sublane_ctrl #(
   parameter int MAX_VL_PER_LANE = 256
) (
   input  logic                               clk_i,
   input  logic                               rstn_i,
   input  logic                               start_i,
   input  sublane_pkg::inst_kind_e            kind_i,
   input  logic [$clog2(MAX_VL_PER_LANE):0]   elems_i,
   input  logic [$clog2(MAX_VL_PER_LANE)-1:0] inst_delay_i,
   input  logic                               load_valid_i,
   input  logic                               load_last_i,
   output logic                               ready_o,
   output logic                               cnt_load_o,
   output logic                               rd_step_o,
   output logic                               wr_step_o,
   output logic                               store_valid_o,
   output logic                               load_phase_o,
   output logic                               src_load_o
);
   import sublane_pkg::*;

   localparam int CNT_W = $clog2(MAX_VL_PER_LANE) + 2;  // room for L + delay + 1

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_NORMAL,
      ST_READ,
      ST_LOAD
   } state_e;

   state_e           state_q;
   state_e           state_d;
   logic [CNT_W-1:0] cnt_q;
   logic [CNT_W-1:0] cnt_nxt;
   logic [CNT_W-1:0] rd_lim;
   logic [CNT_W-1:0] wr_lim;
   logic             accept;
   logic             in_read;
   logic             in_write;

   assign accept     = start_i & ready_o;
   assign cnt_load_o = accept;

   //////////////////////////////////////////////////
   // element counter, zero on the first read cycle
   //////////////////////////////////////////////////
   assign cnt_nxt  = cnt_q + 1'b1;
   assign rd_lim   = CNT_W'(elems_i);
   assign wr_lim   = CNT_W'(elems_i) + CNT_W'(inst_delay_i);
   assign in_read  = cnt_q < rd_lim;
   assign in_write = (cnt_q >= CNT_W'(inst_delay_i)) && (cnt_q < wr_lim);

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         cnt_q <= '0;
      end else if (accept) begin
         cnt_q <= '0;
      end else if (state_q == ST_NORMAL || state_q == ST_READ) begin
         cnt_q <= cnt_nxt;
      end
   end

   //////////////////////////////////////////////////
   // state machine
   //////////////////////////////////////////////////
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (accept) begin
               case (kind_i)
                  KIND_NORMAL: state_d = ST_NORMAL;
                  KIND_STORE:  state_d = ST_READ;
                  KIND_LOAD:   state_d = ST_LOAD;
                  default:     state_d = ST_IDLE;  // unknown kind, nothing to run
               endcase
            end
         end
         ST_NORMAL: if (cnt_nxt >= wr_lim) state_d = ST_IDLE;  // leave with the last write
         ST_READ:   if (cnt_nxt >= rd_lim) state_d = ST_IDLE;
         ST_LOAD:   if (load_last_i) state_d = ST_IDLE;
         default:   state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // ready comes back one cycle after idle is reached, so the last
   // registered strobe is already out
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         ready_o <= 1'b1;
      end else if (accept) begin
         ready_o <= 1'b0;
      end else if (state_q == ST_IDLE) begin
         ready_o <= 1'b1;
      end
   end

   // phase strobes, registered once more in the top
   assign rd_step_o     = (state_q == ST_NORMAL || state_q == ST_READ) && in_read;
   assign store_valid_o = (state_q == ST_READ) && in_read;
   assign wr_step_o     = ((state_q == ST_NORMAL) && in_write) ||
                          ((state_q == ST_LOAD) && load_valid_i);  // one write per beat
   assign load_phase_o  = (state_q == ST_LOAD) && !load_last_i;
   assign src_load_o    = (state_q == ST_LOAD);

endmodule

// ==== vrf_addr_counter.sv ====
`timescale 1ns/10ps

module vrf_addr_counter #(
   parameter int MEM_DEPTH       = 512,
   parameter int MAX_VL_PER_LANE = 256
) (
   input  logic                         clk_i,
   input  logic                         rstn_i,
   input  logic                         load_i,
   input  logic                         step_i,
   input  logic [$clog2(MEM_DEPTH)-1:0] base_i,
   input  sublane_pkg::sew_e            sew_i,
   output logic [$clog2(MEM_DEPTH)-1:0] addr_o
);
   import sublane_pkg::*;

   localparam int AW    = $clog2(MEM_DEPTH);
   localparam int IDX_W = $clog2(MAX_VL_PER_LANE) + 1;

   logic [AW-1:0]    base_q;
   logic [IDX_W-1:0] idx_q;      // element index inside the lane
   logic [IDX_W-1:0] word_idx;

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         idx_q <= '0;
      end else if (load_i) begin
         idx_q <= '0;
      end else if (step_i) begin
         idx_q <= idx_q + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (load_i) base_q <= base_i;
   end

   // four bytes or two halves share one word
   always_comb begin
      case (sew_i)
         SEW_BYTE: word_idx = idx_q >> 2;
         SEW_HALF: word_idx = idx_q >> 1;
         default:  word_idx = idx_q;
      endcase
   end

   assign addr_o = base_q + AW'(word_idx);

endmodule

// ==== bwen_gen.sv ====
`timescale 1ns/10ps

module bwen_gen #(
   parameter int VLANE_NUM = 8
) (
   input  logic                      clk_i,
   input  logic                      rstn_i,
   input  logic                      restart_i,
   input  logic                      step_i,
   input  sublane_pkg::sew_e         sew_i,
   output logic [VLANE_NUM-1:0][3:0] bwen_o
);
   import sublane_pkg::*;

   logic [3:0] rot4_q;   // byte position in the word
   logic [1:0] rot2_q;   // half position in the word
   logic [3:0] pat;

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         rot4_q <= 4'b0001;
         rot2_q <= 2'b01;
      end else if (restart_i) begin
         rot4_q <= 4'b0001;
         rot2_q <= 2'b01;
      end else if (step_i) begin
         rot4_q <= {rot4_q[2:0], rot4_q[3]};
         rot2_q <= {rot2_q[0], rot2_q[1]};
      end
   end

   always_comb begin
      case (sew_i)
         SEW_BYTE: pat = rot4_q;
         SEW_HALF: pat = {{2{rot2_q[1]}}, {2{rot2_q[0]}}};  // 0011 even, 1100 odd
         SEW_WORD: pat = 4'b1111;
         default:  pat = 4'b0000;
      endcase
   end

   // all lanes sit at the same element position
   assign bwen_o = {VLANE_NUM{pat}};

endmodule

// ==== lane_valid_gen.sv ====
`timescale 1ns/10ps

module lane_valid_gen #(
   parameter int VLANE_NUM       = 8,
   parameter int MAX_VL_PER_LANE = 256
) (
   input  logic                                       clk_i,
   input  logic                                       rstn_i,
   input  logic                                       load_i,
   input  logic                                       step_i,
   input  logic [$clog2(VLANE_NUM*MAX_VL_PER_LANE):0] vl_i,
   output logic [VLANE_NUM-1:0]                       valid_o
);
   localparam int VW = $clog2(VLANE_NUM * MAX_VL_PER_LANE) + 1;

   logic [VW-1:0] rem_q;  // elements not yet handed to a read group

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         rem_q <= '0;
      end else if (load_i) begin
         rem_q <= vl_i;
      end else if (step_i) begin
         if (rem_q > VW'(VLANE_NUM)) begin
            rem_q <= rem_q - VW'(VLANE_NUM);
         end else begin
            rem_q <= '0;  // partial last group used up
         end
      end
   end

   always_comb begin
      for (int j = 0; j < VLANE_NUM; j++) begin
         valid_o[j] = rem_q > VW'(j);
      end
   end

endmodule

// ==== sublane_driver.sv ====
`timescale 1ns/10ps

module sublane_driver #(
   parameter int VLANE_NUM       = sublane_pkg::VLANE_NUM,
   parameter int MEM_DEPTH       = sublane_pkg::MEM_DEPTH,
   parameter int MAX_VL_PER_LANE = sublane_pkg::MAX_VL_PER_LANE
) (
   input  logic                      clk_i,
   input  logic                      rstn_i,
   input  logic                      start_i,
   input  sublane_pkg::inst_cfg_t    cfg_i,
   input  logic                      load_valid_i,
   input  logic                      load_last_i,
   input  logic [VLANE_NUM-1:0][3:0] load_bwen_i,
   output logic                      ready_o,
   output sublane_pkg::vrf_rd_t      rd_o,
   output sublane_pkg::vrf_wr_t      wr_o,
   output logic                      store_data_valid_o,
   output logic                      ready_for_load_o
);
   import sublane_pkg::*;

   localparam int LANE_SH = $clog2(VLANE_NUM);
   localparam int LEN_W   = $clog2(MAX_VL_PER_LANE) + 1;

   inst_cfg_t                       cfg_q;
   logic [VL_W-1:0]                 vl_round;
   logic [LEN_W-1:0]                elems;      // L, elements per lane
   logic                            cnt_load;
   logic                            rd_step;
   logic                            wr_step;
   logic                            store_valid;
   logic                            load_phase;
   logic                            src_load;
   sew_e                            rd_sew;
   sew_e                            wr_sew;
   logic [RD_PORTS-1:0][ADDR_W-1:0] raddr;
   logic [ADDR_W-1:0]               waddr;
   logic [VLANE_NUM-1:0][3:0]       gen_bwen;
   logic [VLANE_NUM-1:0]            lane_valid;
   vrf_rd_t                         rd_d;
   vrf_wr_t                         wr_d;

   always_ff @(posedge clk_i) begin
      if (cnt_load) cfg_q <= cfg_i;
   end

   assign vl_round = cfg_q.vl + VL_W'(VLANE_NUM - 1);
   assign elems    = vl_round[LANE_SH +: LEN_W];  // ceil(vl / lanes)

   assign rd_sew = store_valid ? SEW_WORD : cfg_q.rd_sew;  // stores read whole words
   assign wr_sew = src_load ? SEW_WORD : cfg_q.wr_sew;

   sublane_ctrl #(.MAX_VL_PER_LANE(MAX_VL_PER_LANE)) i_ctrl (
      .clk_i(clk_i), .rstn_i(rstn_i), .start_i(start_i),
      .kind_i(cfg_i.kind), .elems_i(elems), .inst_delay_i(cfg_q.inst_delay),
      .load_valid_i(load_valid_i), .load_last_i(load_last_i),
      .ready_o(ready_o), .cnt_load_o(cnt_load), .rd_step_o(rd_step), .wr_step_o(wr_step),
      .store_valid_o(store_valid), .load_phase_o(load_phase), .src_load_o(src_load)
   );

   // counters load straight from cfg_i in the accept cycle
   vrf_addr_counter #(.MEM_DEPTH(MEM_DEPTH), .MAX_VL_PER_LANE(MAX_VL_PER_LANE)) i_waddr_cnt (
      .clk_i(clk_i), .rstn_i(rstn_i), .load_i(cnt_load), .step_i(wr_step),
      .base_i(cfg_i.wr_base), .sew_i(wr_sew), .addr_o(waddr)
   );

   for (genvar p = 0; p < RD_PORTS; p++) begin : g_rd
      vrf_addr_counter #(.MEM_DEPTH(MEM_DEPTH), .MAX_VL_PER_LANE(MAX_VL_PER_LANE)) i_raddr_cnt (
         .clk_i(clk_i), .rstn_i(rstn_i), .load_i(cnt_load), .step_i(rd_step),
         .base_i(cfg_i.rd_base[p]), .sew_i(rd_sew), .addr_o(raddr[p])
      );
   end

   bwen_gen #(.VLANE_NUM(VLANE_NUM)) i_bwen_gen (
      .clk_i(clk_i), .rstn_i(rstn_i), .restart_i(cnt_load), .step_i(wr_step),
      .sew_i(cfg_q.wr_sew), .bwen_o(gen_bwen)
   );

   lane_valid_gen #(.VLANE_NUM(VLANE_NUM), .MAX_VL_PER_LANE(MAX_VL_PER_LANE)) i_lane_valid (
      .clk_i(clk_i), .rstn_i(rstn_i), .load_i(cnt_load), .step_i(rd_step),
      .vl_i(cfg_i.vl), .valid_o(lane_valid)
   );

   //////////////////////////////////////////////////
   // output registers, one cycle behind the strobes
   //////////////////////////////////////////////////
   always_comb begin
      rd_d.en       = rd_step;
      rd_d.addr     = raddr;
      rd_d.valid    = rd_step ? lane_valid : '0;
      wr_d.en       = wr_step;
      wr_d.addr     = waddr;
      wr_d.bwen     = src_load ? load_bwen_i : gen_bwen;  // load beat brings its own
      wr_d.src_load = src_load;
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         rd_o               <= '0;
         wr_o               <= '0;
         store_data_valid_o <= 1'b0;
         ready_for_load_o   <= 1'b0;
      end else begin
         rd_o               <= rd_d;
         wr_o               <= wr_d;
         store_data_valid_o <= store_valid;
         ready_for_load_o   <= load_phase;
      end
   end

endmodule

// ==== sublane_driver_assert.sv ====
`timescale 1ns/10ps

module sublane_driver_assert (
   input logic                 clk_i,
   input logic                 rstn_i,
   input logic                 ready_i,
   input sublane_pkg::vrf_rd_t rd_i,
   input sublane_pkg::vrf_wr_t wr_i,
   input logic                 store_valid_i,
   input logic                 load_ready_i
);

   // store data only goes out together with a read
   a_store_with_read: assert property (@(posedge clk_i) disable iff (!rstn_i)
      $rose(store_valid_i) |-> rd_i.en)
      else $error("store_data_valid_o rose without a read enable");

   a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rstn_i)
      ready_i |-> !(rd_i.en || wr_i.en))   // nothing moves while idle
      else $error("read or write enable high while ready_o is high");

   a_load_no_read: assert property (@(posedge clk_i) disable iff (!rstn_i)
      !(load_ready_i && rd_i.en))
      else $error("ready_for_load_o and read enable high together");

endmodule

bind sublane_driver sublane_driver_assert i_sublane_driver_assert (
   .clk_i(clk_i), .rstn_i(rstn_i), .ready_i(ready_o), .rd_i(rd_o), .wr_i(wr_o),
   .store_valid_i(store_data_valid_o), .load_ready_i(ready_for_load_o)
);

// ==== sublane_checker.sv ====
`timescale 1ns/10ps

module sublane_checker #(
   parameter int VLANE_NUM = 8
) (
   input  logic                      clk_i,
   input  logic                      rstn_i,
   input  logic                      start_i,
   input  sublane_pkg::inst_cfg_t    cfg_i,
   input  logic                      load_valid_i,
   input  logic                      load_last_i,
   input  logic [VLANE_NUM-1:0][3:0] load_bwen_i,
   input  logic                      ready_i,
   input  sublane_pkg::vrf_rd_t      rd_i,
   input  sublane_pkg::vrf_wr_t      wr_i,
   input  logic                      store_valid_i,
   input  logic                      load_ready_i,
   output int                        errors_o
);
   import sublane_pkg::*;

   inst_cfg_t                 cfg;
   string                     tname = "reset";
   logic                      busy = 1'b0;
   logic                      in_reset = 1'b0;
   logic                      pend = 1'b0;       // load beat seen and its write due now
   logic                      last_seen = 1'b0;
   logic [VLANE_NUM-1:0][3:0] pend_bwen;
   sew_e                      sew;
   int                        errs = 0;
   int                        cyc = 0;
   int                        acc_cyc;
   int                        first_rd;
   int                        last_op;            // last cycle with a read or write
   int                        rd_k;
   int                        wr_k;
   int                        beats;
   int                        inst_no = 0;

   assign errors_o = errs;

   //////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////
   function automatic int lane_len(int vl);
      return (vl + VLANE_NUM - 1) / VLANE_NUM;   // rounded up
   endfunction

   function automatic logic [VLANE_NUM-1:0] valid_bits(int vl, int k);
      logic [VLANE_NUM-1:0] v;
      for (int j = 0; j < VLANE_NUM; j++) begin
         v[j] = (k * VLANE_NUM + j) < vl;
      end
      return v;
   endfunction

   function automatic logic [ADDR_W-1:0] elem_addr(int base, int k, sew_e s);
      int per_word;
      per_word = (s == SEW_BYTE) ? 4 : (s == SEW_HALF) ? 2 : 1;
      return ADDR_W'(base + k / per_word);
   endfunction

   function automatic logic [VLANE_NUM-1:0][3:0] byte_enables(int k, sew_e s);
      logic [3:0] nib;
      case (s)
         SEW_BYTE: nib = 4'b0001 << (k % 4);
         SEW_HALF: nib = (k % 2 == 0) ? 4'b0011 : 4'b1100;
         default:  nib = 4'b1111;
      endcase
      return {VLANE_NUM{nib}};
   endfunction

   task automatic compare(string what, logic [63:0] exp, logic [63:0] act);
      if (exp !== act) begin
         errs++;
         $display("FAILED %s %s: expected 'h%0h, actual 'h%0h", tname, what, exp, act);
      end
   endtask

   task automatic flag(string what);
      errs++;
      $display("%s: %s", tname, what);
   endtask

   //////////////////////////////////////////////////
   // comparing at mid cycle where everything is stable
   //////////////////////////////////////////////////
   always @(negedge clk_i) begin
      cyc++;
      if (!rstn_i) begin
         busy = 1'b0;
         pend = 1'b0;
         in_reset = 1'b1;
      end else begin
         if (in_reset) begin
            in_reset = 1'b0;
            compare("ready after reset", 1, ready_i);
            compare("enables after reset", 0, {rd_i.en, wr_i.en, store_valid_i, load_ready_i});
         end
         if (busy && cyc == acc_cyc + 1) begin
            compare("ready after start", 0, ready_i);
         end
         if (rd_i.en) begin
            last_op = cyc;
            if (!busy || !(cfg.kind == KIND_NORMAL || cfg.kind == KIND_STORE) ||
                rd_k >= lane_len(cfg.vl)) begin
               flag("read enable high outside a read phase");
            end else begin
               if (rd_k == 0) begin
                  first_rd = cyc;
               end
               compare($sformatf("read cycle k=%0d", rd_k), acc_cyc + 2 + rd_k, cyc);
               sew = (cfg.kind == KIND_STORE) ? SEW_WORD : cfg.rd_sew;
               for (int p = 0; p < RD_PORTS; p++) begin
                  compare($sformatf("rd_addr[%0d] k=%0d", p, rd_k),
                          elem_addr(cfg.rd_base[p], rd_k, sew), rd_i.addr[p]);
               end
               compare($sformatf("rd_valid k=%0d", rd_k), valid_bits(cfg.vl, rd_k), rd_i.valid);
               rd_k++;
            end
         end
         compare("store_data_valid", busy && cfg.kind == KIND_STORE && rd_i.en, store_valid_i);

         if (wr_i.en) begin
            last_op = cyc;
            if (!busy || !((cfg.kind == KIND_NORMAL && wr_k < lane_len(cfg.vl)) || pend)) begin
               flag("write enable high with no write due");
            end else begin
               if (!pend) begin
                  compare($sformatf("write cycle k=%0d", wr_k),
                          first_rd + cfg.inst_delay + wr_k, cyc);
               end
               sew = pend ? SEW_WORD : cfg.wr_sew;   // load beats fill whole words
               compare($sformatf("wr_addr k=%0d", wr_k), elem_addr(cfg.wr_base, wr_k, sew),
                       wr_i.addr);
               compare($sformatf("wr_bwen k=%0d", wr_k),
                       pend ? pend_bwen : byte_enables(wr_k, sew), wr_i.bwen);
               compare("wr_src_load", pend, wr_i.src_load);
               wr_k++;
            end
         end else if (pend) begin
            flag("a load beat was not written");
         end

         compare("ready_for_load", busy && cfg.kind == KIND_LOAD && cyc >= acc_cyc + 2 &&
                 !last_seen, load_ready_i);
         pend = busy && cfg.kind == KIND_LOAD && load_valid_i && !last_seen;
         pend_bwen = load_bwen_i;
         if (pend) beats++;
         if (busy && cfg.kind == KIND_LOAD && load_last_i) last_seen = 1'b1;

         if (busy && cyc > acc_cyc + 1 && ready_i) begin   // instruction is over
            compare("ready return cycle", last_op + 1, cyc);
            compare("read count", (cfg.kind == KIND_NORMAL || cfg.kind == KIND_STORE) ?
                    lane_len(cfg.vl) : 0, rd_k);
            compare("write count", (cfg.kind == KIND_NORMAL) ? lane_len(cfg.vl) :
                    (cfg.kind == KIND_LOAD) ? beats : 0, wr_k);
            busy = 1'b0;
         end
         if (start_i && ready_i) begin
            cfg = cfg_i;
            acc_cyc = cyc;
            last_op = cyc + 1;   // bad kind gives ready back right away
            first_rd = cyc + 2;
            rd_k = 0;
            wr_k = 0;
            beats = 0;
            last_seen = 1'b0;
            busy = 1'b1;
            inst_no++;
            tname = $sformatf("%s_%0d", (cfg.kind == KIND_NORMAL) ? "normal" :
                    (cfg.kind == KIND_STORE) ? "store" :
                    (cfg.kind == KIND_LOAD) ? "load" : "bad_kind", inst_no);
         end
      end
   end

endmodule

// ==== tb_sublane_driver.sv ====
`timescale 1ns/10ps

module tb_sublane_driver;
   import sublane_pkg::*;

   localparam int TMO = 2000;   // cycles per wait

   logic                      clk_i = 1'b0;
   logic                      rstn_i;
   logic                      start_i;
   inst_cfg_t                 cfg_i;
   logic                      load_valid_i;
   logic                      load_last_i;
   logic [VLANE_NUM-1:0][3:0] load_bwen_i;
   logic                      ready_o;
   vrf_rd_t                   rd_o;
   vrf_wr_t                   wr_o;
   logic                      store_data_valid_o;
   logic                      ready_for_load_o;
   int                        chk_errors;
   int                        tmo_errors = 0;
   int                        seed = 32'h8cce_c6b4;

   always #2 clk_i = ~clk_i;

   sublane_driver #(
      .VLANE_NUM(VLANE_NUM), .MEM_DEPTH(MEM_DEPTH), .MAX_VL_PER_LANE(MAX_VL_PER_LANE)
   ) i_sublane_driver (.*);

   sublane_checker #(.VLANE_NUM(VLANE_NUM)) i_checker (
      .clk_i(clk_i), .rstn_i(rstn_i), .start_i(start_i), .cfg_i(cfg_i),
      .load_valid_i(load_valid_i), .load_last_i(load_last_i), .load_bwen_i(load_bwen_i),
      .ready_i(ready_o), .rd_i(rd_o), .wr_i(wr_o), .store_valid_i(store_data_valid_o),
      .load_ready_i(ready_for_load_o), .errors_o(chk_errors)
   );

   function automatic int rnd(int n);
      return $unsigned($random(seed)) % n;
   endfunction

   // polls 1 ns after each rising edge
   task automatic wait_for(input bit load_side, input string what);
      int n;
      n = 0;
      while (!(load_side ? ready_for_load_o : ready_o) && n < TMO) begin
         @(posedge clk_i);
         #1;
         n++;
      end
      if (!(load_side ? ready_for_load_o : ready_o)) begin
         tmo_errors++;
         $display("timeout while waiting for %s", what);
      end
   endtask

   task automatic issue(input inst_kind_e kind, input sew_e rs, input sew_e ws);
      inst_cfg_t c;
      c.kind       = kind;
      c.vl         = VL_W'(1 + rnd(12 * VLANE_NUM));   // up to 12 groups, last one partial
      c.rd_sew     = rs;
      c.wr_sew     = ws;
      c.wr_base    = ADDR_W'(rnd(MEM_DEPTH));
      c.inst_delay = DLY_W'(rnd(8));
      for (int p = 0; p < RD_PORTS; p++) begin
         c.rd_base[p] = ADDR_W'(rnd(MEM_DEPTH));
      end
      wait_for(0, "ready before start");
      start_i = 1'b1;
      cfg_i   = c;
      @(posedge clk_i);
      #1;
      start_i = 1'b0;
   endtask

   task automatic load_beats(input int n);
      for (int i = 0; i < n; i++) begin
         repeat (rnd(3)) begin   // idle gap before the beat
            @(posedge clk_i);
            #1;
         end
         load_valid_i = 1'b1;
         load_last_i  = (i == n - 1);
         load_bwen_i  = $random(seed);
         @(posedge clk_i);
         #1;
         load_valid_i = 1'b0;
         load_last_i  = 1'b0;
      end
   endtask

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////
   initial begin
      rstn_i       = 1'b0;
      start_i      = 1'b0;
      cfg_i        = '0;
      load_valid_i = 1'b0;
      load_last_i  = 1'b0;
      load_bwen_i  = '0;
      repeat (3) @(posedge clk_i);
      #1;
      rstn_i = 1'b1;
      for (int t = 0; t < 9; t++) begin   // every read and write width pair
         issue(KIND_NORMAL, sew_e'(t % 3), sew_e'(t / 3));
         wait_for(0, "end of normal instruction");
      end
      for (int t = 0; t < 3; t++) begin
         issue(KIND_STORE, sew_e'(t), SEW_WORD);
         wait_for(0, "end of store instruction");
      end
      for (int t = 0; t < 4; t++) begin
         issue(KIND_LOAD, SEW_WORD, SEW_WORD);
         wait_for(1, "ready_for_load_o");
         load_beats(1 + rnd(12));
         wait_for(0, "end of load instruction");
      end
      issue(inst_kind_e'(2'b11), SEW_WORD, SEW_WORD);
      wait_for(0, "return from unknown kind");
      repeat (4) @(posedge clk_i);
      $display("errors: %0d from checks, %0d from timeouts", chk_errors, tmo_errors);
      if (chk_errors == 0 && tmo_errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
sublane_pkg.sv
sublane_ctrl.sv
vrf_addr_counter.sv
bwen_gen.sv
lane_valid_gen.sv
sublane_driver.sv
sublane_driver_assert.sv
sublane_checker.sv
tb_sublane_driver.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_sublane_driver \
   -f filelist.f -o sim_tb \
   && ./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log \
   && grep -q "^Testbench passed$" sim.log \
   || { echo "simulation did not pass"; exit 1; }
